/* logic/tx_ctrl_pkg.sv */
// tx control shared definitions
`default_nettype none

package tx_ctrl_pkg;

  // frame control type codes
  localparam logic [1:0] fc_type_mgmt = 2'b00;
  localparam logic [1:0] fc_type_ctrl = 2'b01;
  localparam logic [1:0] fc_type_data = 2'b10;

  // ack subtype, and the mgmt subtype that never gets an ack
  localparam logic [3:0] fc_subtype_ack         = 4'b1101;
  localparam logic [3:0] fc_subtype_beacon_excl = 4'b1110;

  // an ack is always 14 bytes on air
  localparam logic [11:0] ack_signal_len = 12'd14;

  // field widths
  localparam int mac_addr_w = 48;
  localparam int dur_w      = 16;
  localparam int rate_w     = 4;
  localparam int sig_len_w  = 16;
  localparam int count_w    = 15;
  localparam int retrans_w  = 4;

  // tx buffer layout
  localparam int buf_data_w = 64;
  localparam int buf_addr_w = 10;
  localparam int ack_words  = 4;
  localparam int ack_seq_w  = $clog2(ack_words);

  // received frame header, valid with fcs_done
  typedef struct packed {
    logic                  fcs_ok;
    logic [1:0]            fc_type;
    logic [3:0]            fc_subtype;
    logic                  more_frag;
    logic [dur_w-1:0]      duration;
    logic [mac_addr_w-1:0] addr1;
    logic [mac_addr_w-1:0] addr2;
  } rx_frame_t;

  // signal field report from the rx phy
  typedef struct packed {
    logic                 sig_valid;
    logic [sig_len_w-1:0] signal_len;
  } rx_sig_t;

  // software configuration
  typedef struct packed {
    logic [mac_addr_w-1:0] self_mac_addr;
    logic [rate_w-1:0]     ack_rate;
    logic [dur_w-1:0]      duration_extra;
    logic [dur_w-1:0]      ack_overhead;
    logic [count_w-1:0]    send_ack_wait;
    logic [count_w-1:0]    sig_valid_timeout;
    logic [count_w-1:0]    ack_timeout;
    logic [retrans_w-1:0]  max_num_retrans;
    logic                  fcs_check_disable;
  } ack_cfg_t;

  // one tx buffer write
  typedef struct packed {
    logic                  wea;
    logic [buf_addr_w-1:0] addra;
    logic [buf_data_w-1:0] dina;
  } buf_wr_t;

  // completion status
  typedef struct packed {
    logic                 fail;
    logic [retrans_w-1:0] num_retrans;
  } tx_status_t;

endpackage

`default_nettype wire

/* logic/rx_frame_classifier.sv */
// received frame classifier
`timescale 1ns/1ns
`default_nettype none

module rx_frame_classifier (
  input  logic                  clk,
  input  logic                  rstn,
  input  tx_ctrl_pkg::rx_frame_t rx_frame,
  input  logic                  fcs_done,
  input  tx_ctrl_pkg::ack_cfg_t cfg,
  input  logic                  ack_tx_busy,
  input  logic                  retrans_in_progress,
  output logic                  ack_req,
  output logic                  ack_match,
  output logic [47:0]           ack_addr,
  output logic [15:0]           ack_duration
);

  logic to_self;
  logic is_data;
  logic is_mgmt;
  logic is_ack;
  logic want_ack;
  logic got_ack;

  assign to_self = (rx_frame.addr1 == cfg.self_mac_addr);
  assign is_data = (rx_frame.fc_type == tx_ctrl_pkg::fc_type_data);
  // beacons are broadcast and never acked
  assign is_mgmt = (rx_frame.fc_type == tx_ctrl_pkg::fc_type_mgmt) &&
                   (rx_frame.fc_subtype != tx_ctrl_pkg::fc_subtype_beacon_excl);
  assign is_ack  = (rx_frame.fc_type == tx_ctrl_pkg::fc_type_ctrl) &&
                   (rx_frame.fc_subtype == tx_ctrl_pkg::fc_subtype_ack);

  // no new response while one is pending or while waiting for our own ack
  assign want_ack = fcs_done && rx_frame.fcs_ok && (is_data || is_mgmt) && to_self &&
                    !ack_tx_busy && !ack_req && !retrans_in_progress;
  // fcs may be waived for the peer ack
  assign got_ack  = fcs_done && (rx_frame.fcs_ok || cfg.fcs_check_disable) && is_ack && to_self;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ack_req   <= 1'b0;
      ack_match <= 1'b0;
    end else begin
      ack_req   <= want_ack;
      ack_match <= got_ack;
    end
  end

  // ra comes from addr2 of the frame being acked
  always_ff @(posedge clk) begin
    if (want_ack) begin
      ack_addr <= rx_frame.addr2;
      // last fragment gets only the extra value
      if (!rx_frame.more_frag) begin
        ack_duration <= cfg.duration_extra;
      end else begin
        ack_duration <= rx_frame.duration - cfg.ack_overhead + cfg.duration_extra;
      end
    end
  end

  // ack response and ack match are exclusive
  a_req_match_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(ack_req && ack_match));

endmodule

`default_nettype wire

/* logic/ack_frame_writer.sv */
// ack frame writer
`timescale 1ns/1ns
`default_nettype none

module ack_frame_writer (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  ack_req,
  input  logic [47:0]           ack_addr,
  input  logic [15:0]           ack_duration,
  input  tx_ctrl_pkg::ack_cfg_t cfg,
  input  logic                  phy_tx_done,
  output tx_ctrl_pkg::buf_wr_t  buf_wr,
  output logic                  ack_tx_busy
);

  typedef enum logic [1:0] {
    w_idle,
    w_wait,
    w_write,
    w_hold
  } wr_state_t;

  wr_state_t                          state;
  logic [tx_ctrl_pkg::count_w-1:0]    wait_cnt;
  logic [tx_ctrl_pkg::ack_seq_w-1:0]  seq;
  logic [47:0]                        addr_q;
  logic [15:0]                        dur_q;
  logic                               sig_parity;

  // length 14 has three ones, so parity folds into the rate bits
  assign sig_parity = ~(^cfg.ack_rate);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= w_idle;
      wait_cnt <= '0;
      seq      <= '0;
    end else begin
      case (state)
        w_idle: begin
          seq      <= '0;
          wait_cnt <= 15'd1;
          if (ack_req) begin
            // zero wait goes straight to the buffer writes
            state <= (cfg.send_ack_wait == '0) ? w_write : w_wait;
          end
        end
        w_wait: begin
          if (wait_cnt >= cfg.send_ack_wait) begin
            state <= w_write;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        w_write: begin
          seq <= seq + 1'b1;
          if (seq == tx_ctrl_pkg::ack_seq_w'(tx_ctrl_pkg::ack_words - 1)) begin
            state <= w_hold;
          end
        end
        // stay busy until the ack has left the radio
        w_hold: begin
          if (phy_tx_done) begin
            state <= w_idle;
          end
        end
        default: state <= w_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ack_req && state == w_idle) begin
      addr_q <= ack_addr;
      dur_q  <= ack_duration;
    end
  end

  assign ack_tx_busy = (state != w_idle);

  // word mux for the four ack words
  always_comb begin
    buf_wr.wea   = (state == w_write);
    buf_wr.addra = {{(tx_ctrl_pkg::buf_addr_w - tx_ctrl_pkg::ack_seq_w){1'b0}}, seq};
    case (seq)
      // signal word
      2'd0: buf_wr.dina = {46'd0, sig_parity, tx_ctrl_pkg::ack_signal_len, 1'b0, cfg.ack_rate};
      2'd1: buf_wr.dina = '0;
      // frame control, duration, low ra bits
      2'd2: buf_wr.dina = {addr_q[31:0], dur_q, 8'd0, tx_ctrl_pkg::fc_subtype_ack,
                           tx_ctrl_pkg::fc_type_ctrl, 2'b00};
      default: buf_wr.dina = {48'd0, addr_q[47:32]};
    endcase
  end

  // classifier must hold off while a response is in flight
  a_no_req_when_busy: assert property (@(posedge clk) disable iff (!rstn)
    ack_req |-> !ack_tx_busy);

endmodule

`default_nettype wire

/* logic/ack_waiter.sv */
// ack wait and retransmit control
`timescale 1ns/1ns
`default_nettype none

module ack_waiter (
  input  logic                    clk,
  input  logic                    rstn,
  input  tx_ctrl_pkg::ack_cfg_t   cfg,
  input  logic                    phy_tx_done,
  input  logic                    tx_bb_end,
  input  logic                    ack_tx_busy,
  input  logic                    ack_match,
  input  tx_ctrl_pkg::rx_sig_t    rx_sig,
  input  logic                    tx_pkt_need_ack,
  input  logic [3:0]              tx_pkt_retrans_limit,
  output logic                    retrans_in_progress,
  output logic                    start_retrans,
  output logic                    tx_try_complete,
  output logic                    waiter_idle,
  output tx_ctrl_pkg::tx_status_t tx_status
);

  typedef enum logic [2:0] {
    s_idle,
    s_judge,
    s_wait_bb,
    s_wait_sig,
    s_wait_ack
  } wait_state_t;

  wait_state_t                       state;
  logic [tx_ctrl_pkg::retrans_w-1:0] num_retrans;
  logic [tx_ctrl_pkg::retrans_w-1:0] pkt_limit;
  logic [tx_ctrl_pkg::retrans_w-1:0] retrans_limit;
  logic [tx_ctrl_pkg::count_w-1:0]   timeout_cnt;
  logic                              sig_is_ack;

  // global limit wins when set
  assign retrans_limit = (cfg.max_num_retrans != '0) ? cfg.max_num_retrans : pkt_limit;
  // only a 14 byte signal can be the peer ack
  assign sig_is_ack = rx_sig.sig_valid &&
                      (rx_sig.signal_len == {4'd0, tx_ctrl_pkg::ack_signal_len});

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state               <= s_idle;
      num_retrans         <= '0;
      pkt_limit           <= '0;
      timeout_cnt         <= '0;
      retrans_in_progress <= 1'b0;
      start_retrans       <= 1'b0;
      tx_try_complete     <= 1'b0;
      tx_status           <= '0;
    end else begin
      // single cycle strobes
      start_retrans   <= 1'b0;
      tx_try_complete <= 1'b0;
      case (state)
        s_idle: begin
          // tx done of our own ack is not a data packet
          if (phy_tx_done && !ack_tx_busy) begin
            pkt_limit <= tx_pkt_retrans_limit;
            if (tx_pkt_need_ack) begin
              retrans_in_progress <= 1'b1;
              state               <= s_wait_bb;
            end else begin
              tx_try_complete       <= 1'b1;
              tx_status.fail        <= 1'b0;
              tx_status.num_retrans <= num_retrans;
              num_retrans           <= '0;
              retrans_in_progress   <= 1'b0;
            end
          end
        end
        s_wait_bb: begin
          timeout_cnt <= '0;
          if (tx_bb_end) begin
            state <= s_wait_sig;
          end
        end
        // signal field of the ack must show up in time
        s_wait_sig: begin
          if (sig_is_ack && timeout_cnt < cfg.sig_valid_timeout) begin
            timeout_cnt <= '0;
            state       <= s_wait_ack;
          end else if (timeout_cnt >= cfg.sig_valid_timeout) begin
            state <= s_judge;
          end else begin
            timeout_cnt <= timeout_cnt + 1'b1;
          end
        end
        s_wait_ack: begin
          if (ack_match && timeout_cnt < cfg.ack_timeout) begin
            tx_try_complete       <= 1'b1;
            tx_status.fail        <= 1'b0;
            tx_status.num_retrans <= num_retrans;
            num_retrans           <= '0;
            retrans_in_progress   <= 1'b0;
            state                 <= s_idle;
          end else if (timeout_cnt >= cfg.ack_timeout) begin
            state <= s_judge;
          end else begin
            timeout_cnt <= timeout_cnt + 1'b1;
          end
        end
        // timed out, retry or give up
        s_judge: begin
          if (num_retrans >= retrans_limit || retrans_limit == '0) begin
            tx_try_complete       <= 1'b1;
            tx_status.fail        <= 1'b1;
            tx_status.num_retrans <= num_retrans;
            num_retrans           <= '0;
            retrans_in_progress   <= 1'b0;
          end else begin
            num_retrans   <= num_retrans + 1'b1;
            start_retrans <= 1'b1;
          end
          state <= s_idle;
        end
        default: state <= s_idle;
      endcase
    end
  end

  assign waiter_idle = (state == s_idle);

  a_retry_xor_done: assert property (@(posedge clk) disable iff (!rstn)
    !(start_retrans && tx_try_complete));

  // a retry always keeps the retransmit window open
  a_retry_in_window: assert property (@(posedge clk) disable iff (!rstn)
    start_retrans |-> retrans_in_progress);

endmodule

`default_nettype wire

/* logic/tx_control.sv */
// tx mac control top
`timescale 1ns/1ns
`default_nettype none

module tx_control (
  input  logic                    clk,
  input  logic                    rstn,
  input  tx_ctrl_pkg::ack_cfg_t   cfg,
  input  tx_ctrl_pkg::rx_frame_t  rx_frame,
  input  logic                    fcs_done,
  input  tx_ctrl_pkg::rx_sig_t    rx_sig,
  input  logic                    phy_tx_done,
  input  logic                    tx_bb_end,
  input  logic                    tx_pkt_need_ack,
  input  logic [3:0]              tx_pkt_retrans_limit,
  output tx_ctrl_pkg::buf_wr_t    buf_wr,
  output logic                    ack_tx_busy,
  output logic                    retrans_in_progress,
  output logic                    start_retrans,
  output logic                    tx_try_complete,
  output tx_ctrl_pkg::tx_status_t tx_status,
  output logic                    tx_control_idle
);

  logic        ack_req;
  logic        ack_match;
  logic [47:0] ack_addr;
  logic [15:0] ack_duration;
  logic        waiter_idle;

  // rx side decode
  rx_frame_classifier i_rx_frame_classifier (
    .clk                 (clk),
    .rstn                (rstn),
    .rx_frame            (rx_frame),
    .fcs_done            (fcs_done),
    .cfg                 (cfg),
    .ack_tx_busy         (ack_tx_busy),
    .retrans_in_progress (retrans_in_progress),
    .ack_req             (ack_req),
    .ack_match           (ack_match),
    .ack_addr            (ack_addr),
    .ack_duration        (ack_duration)
  );

  // ack response into the tx buffer
  ack_frame_writer i_ack_frame_writer (
    .clk          (clk),
    .rstn         (rstn),
    .ack_req      (ack_req),
    .ack_addr     (ack_addr),
    .ack_duration (ack_duration),
    .cfg          (cfg),
    .phy_tx_done  (phy_tx_done),
    .buf_wr       (buf_wr),
    .ack_tx_busy  (ack_tx_busy)
  );

  // wait for the peer ack after our own packet
  ack_waiter i_ack_waiter (
    .clk                  (clk),
    .rstn                 (rstn),
    .cfg                  (cfg),
    .phy_tx_done          (phy_tx_done),
    .tx_bb_end            (tx_bb_end),
    .ack_tx_busy          (ack_tx_busy),
    .ack_match            (ack_match),
    .rx_sig               (rx_sig),
    .tx_pkt_need_ack      (tx_pkt_need_ack),
    .tx_pkt_retrans_limit (tx_pkt_retrans_limit),
    .retrans_in_progress  (retrans_in_progress),
    .start_retrans        (start_retrans),
    .tx_try_complete      (tx_try_complete),
    .waiter_idle          (waiter_idle),
    .tx_status            (tx_status)
  );

  // idle only between retry sequences
  assign tx_control_idle = waiter_idle && !retrans_in_progress;

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rstn
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // 16 cycles of reset and release on a falling edge
  initial begin
    rstn = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_tx_control.sv */
// tx control testbench
`timescale 1ns/1ns
`default_nettype none

module tb_tx_control;

  logic                    clk;
  logic                    rstn;
  tx_ctrl_pkg::ack_cfg_t   cfg;
  tx_ctrl_pkg::rx_frame_t  rx_frame;
  logic                    fcs_done;
  tx_ctrl_pkg::rx_sig_t    rx_sig;
  logic                    phy_tx_done;
  logic                    tx_bb_end;
  logic                    tx_pkt_need_ack;
  logic [3:0]              tx_pkt_retrans_limit;
  tx_ctrl_pkg::buf_wr_t    buf_wr;
  logic                    ack_tx_busy;
  logic                    retrans_in_progress;
  logic                    start_retrans;
  logic                    tx_try_complete;
  tx_ctrl_pkg::tx_status_t tx_status;
  logic                    tx_control_idle;

  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          fcs_cycle;
  int          seed_val;
  logic [9:0]  wr_addr[$];
  logic [63:0] wr_data[$];
  int          wr_cycle[$];

  tb_clock i_tb_clock (
    .clk  (clk),
    .rstn (rstn)
  );

  tx_control i_tx_control (
    .clk                  (clk),
    .rstn                 (rstn),
    .cfg                  (cfg),
    .rx_frame             (rx_frame),
    .fcs_done             (fcs_done),
    .rx_sig               (rx_sig),
    .phy_tx_done          (phy_tx_done),
    .tx_bb_end            (tx_bb_end),
    .tx_pkt_need_ack      (tx_pkt_need_ack),
    .tx_pkt_retrans_limit (tx_pkt_retrans_limit),
    .buf_wr               (buf_wr),
    .ack_tx_busy          (ack_tx_busy),
    .retrans_in_progress  (retrans_in_progress),
    .start_retrans        (start_retrans),
    .tx_try_complete      (tx_try_complete),
    .tx_status            (tx_status),
    .tx_control_idle      (tx_control_idle)
  );

  // buffer write monitor, one entry per write cycle
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (rstn && buf_wr.wea) begin
      wr_addr.push_back(buf_wr.addra);
      wr_data.push_back(buf_wr.dina);
      wr_cycle.push_back(cycle_cnt);
    end
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("at time %0t: timed out waiting for %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  function automatic logic [47:0] random_mac();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[47:0];
  endfunction

  function automatic logic [15:0] random_dur();
    return 16'(200 + ($urandom % 3000));
  endfunction

  // ack word layout from the buffer format
  function automatic logic [63:0] ack_word(input int idx, input logic [3:0] rate,
                                           input logic [15:0] dur, input logic [47:0] ra);
    logic [63:0] w;
    w = '0;
    case (idx)
      0: begin
        w[3:0]  = rate;
        w[16:5] = 12'd14;
        w[17]   = ~(^rate);
      end
      2: begin
        w[3:2]   = tx_ctrl_pkg::fc_type_ctrl;
        w[7:4]   = tx_ctrl_pkg::fc_subtype_ack;
        w[31:16] = dur;
        w[63:32] = ra[31:0];
      end
      3: w[15:0] = ra[47:32];
      default: w = '0;
    endcase
    return w;
  endfunction

  task automatic clear_writes();
    wr_addr.delete();
    wr_data.delete();
    wr_cycle.delete();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // all drivers start and end on a falling edge
  task automatic send_frame(input logic [1:0] ftype, input logic [3:0] subtype,
                            input logic more_frag, input logic [15:0] dur,
                            input logic [47:0] addr1, input logic [47:0] addr2);
    rx_frame.fcs_ok     = 1'b1;
    rx_frame.fc_type    = ftype;
    rx_frame.fc_subtype = subtype;
    rx_frame.more_frag  = more_frag;
    rx_frame.duration   = dur;
    rx_frame.addr1      = addr1;
    rx_frame.addr2      = addr2;
    fcs_done            = 1'b1;
    fcs_cycle           = cycle_cnt;
    @(negedge clk);
    fcs_done = 1'b0;
  endtask

  task automatic pulse_tx_done(input logic need_ack, input logic [3:0] limit);
    tx_pkt_need_ack      = need_ack;
    tx_pkt_retrans_limit = limit;
    phy_tx_done          = 1'b1;
    @(negedge clk);
    phy_tx_done = 1'b0;
  endtask

  task automatic pulse_bb_end();
    tx_bb_end = 1'b1;
    @(negedge clk);
    tx_bb_end = 1'b0;
  endtask

  task automatic pulse_sig(input logic [15:0] len);
    rx_sig.signal_len = len;
    rx_sig.sig_valid  = 1'b1;
    @(negedge clk);
    rx_sig.sig_valid = 1'b0;
  endtask

  task automatic wait_writes(input int count, input int max_cycles);
    int n;
    n = 0;
    while (wr_addr.size() < count && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (wr_addr.size() < count) begin
      report_timeout("ack buffer writes");
    end
  endtask

  // stops on the first start_retrans or tx_try_complete strobe
  task automatic wait_try_end(output logic got_retry, output logic got_done,
                              input int max_cycles);
    int n;
    n         = 0;
    got_retry = 1'b0;
    got_done  = 1'b0;
    while (!got_retry && !got_done && n < max_cycles) begin
      @(negedge clk);
      n++;
      got_retry = start_retrans;
      got_done  = tx_try_complete;
    end
    if (!got_retry && !got_done) begin
      report_timeout("start_retrans or tx_try_complete");
    end
  endtask

  task automatic expect_ack_words(input logic [15:0] dur, input logic [47:0] ra);
    check_val("write count", wr_addr.size(), 4);
    for (int i = 0; i < wr_addr.size() && i < 4; i++) begin
      check_val($sformatf("addra[%0d]", i), wr_addr[i], i);
      check_val($sformatf("dina[%0d]", i), wr_data[i], ack_word(i, cfg.ack_rate, dur, ra));
      // four back to back write cycles
      check_val($sformatf("write cycle[%0d]", i), wr_cycle[i] - wr_cycle[0], i);
    end
  endtask

  // end of the ack transmission frees the writer
  task automatic release_ack();
    pulse_tx_done(1'b0, 4'd0);
    check_val("ack_tx_busy", ack_tx_busy, 0);
    check_val("tx_try_complete", tx_try_complete, 0);
  endtask

  task automatic test_reset_values();
    int e0;
    e0 = errors;
    check_val("buf_wr.wea", buf_wr.wea, 0);
    check_val("ack_tx_busy", ack_tx_busy, 0);
    check_val("retrans_in_progress", retrans_in_progress, 0);
    check_val("start_retrans", start_retrans, 0);
    check_val("tx_try_complete", tx_try_complete, 0);
    check_val("tx_status", tx_status, 0);
    check_val("tx_control_idle", tx_control_idle, 1);
    finish_test("test 0 reset values", e0);
  endtask

  task automatic test_ack_last_frag();
    int          e0;
    logic [47:0] peer;
    e0   = errors;
    peer = random_mac();
    clear_writes();
    send_frame(tx_ctrl_pkg::fc_type_data, 4'b0000, 1'b0, random_dur(),
               cfg.self_mac_addr, peer);
    wait_writes(4, 60);
    idle_cycles(6);
    check_val("ack_tx_busy", ack_tx_busy, 1);
    // ack_req, then busy, then the wait, then the sampled write cycle
    if (wr_cycle.size() > 0) begin
      check_val("first write cycle", wr_cycle[0] - fcs_cycle, cfg.send_ack_wait + 3);
    end
    expect_ack_words(cfg.duration_extra, peer);
    release_ack();
    finish_test("test 1 ack last fragment", e0);
  endtask

  task automatic test_ack_more_frag();
    int          e0;
    logic [47:0] peer;
    logic [15:0] dur;
    e0   = errors;
    peer = random_mac();
    dur  = random_dur();
    clear_writes();
    send_frame(tx_ctrl_pkg::fc_type_mgmt, 4'b0000, 1'b1, dur, cfg.self_mac_addr, peer);
    wait_writes(4, 60);
    idle_cycles(2);
    expect_ack_words(dur - cfg.ack_overhead + cfg.duration_extra, peer);
    release_ack();
    // other station, then a beacon to self
    clear_writes();
    send_frame(tx_ctrl_pkg::fc_type_data, 4'b0000, 1'b0, dur,
               cfg.self_mac_addr ^ 48'h1, peer);
    idle_cycles(20);
    send_frame(tx_ctrl_pkg::fc_type_mgmt, tx_ctrl_pkg::fc_subtype_beacon_excl, 1'b0, dur,
               cfg.self_mac_addr, peer);
    idle_cycles(20);
    check_val("write count", wr_addr.size(), 0);
    check_val("ack_tx_busy", ack_tx_busy, 0);
    finish_test("test 2 ack duration and filtering", e0);
  endtask

  task automatic test_no_ack_needed();
    int e0;
    e0 = errors;
    check_val("tx_try_complete", tx_try_complete, 0);
    pulse_tx_done(1'b0, 4'd0);
    // due exactly one cycle after phy_tx_done
    check_val("tx_try_complete", tx_try_complete, 1);
    check_val("tx_status.fail", tx_status.fail, 0);
    check_val("tx_status.num_retrans", tx_status.num_retrans, 0);
    check_val("retrans_in_progress", retrans_in_progress, 0);
    @(negedge clk);
    check_val("tx_try_complete", tx_try_complete, 0);
    finish_test("test 3 no ack needed", e0);
  endtask

  task automatic test_ack_received();
    int   e0;
    logic got_retry;
    logic got_done;
    e0 = errors;
    clear_writes();
    pulse_tx_done(1'b1, 4'd3);
    check_val("retrans_in_progress", retrans_in_progress, 1);
    check_val("tx_control_idle", tx_control_idle, 0);
    pulse_bb_end();
    pulse_sig(16'd14);
    // data frame to self in the middle of the ack wait
    send_frame(tx_ctrl_pkg::fc_type_data, 4'b1000, 1'b0, random_dur(),
               cfg.self_mac_addr, random_mac());
    idle_cycles(8);
    check_val("write count", wr_addr.size(), 0);
    check_val("ack_tx_busy", ack_tx_busy, 0);
    send_frame(tx_ctrl_pkg::fc_type_ctrl, tx_ctrl_pkg::fc_subtype_ack, 1'b0, 16'd0,
               cfg.self_mac_addr, 48'd0);
    wait_try_end(got_retry, got_done, 20);
    check_val("start_retrans", got_retry, 0);
    check_val("tx_try_complete", got_done, 1);
    check_val("tx_status.fail", tx_status.fail, 0);
    check_val("tx_status.num_retrans", tx_status.num_retrans, 0);
    check_val("retrans_in_progress", retrans_in_progress, 0);
    finish_test("test 4 ack received", e0);
  endtask

  // every try times out and odd tries see a valid signal report first
  task automatic run_retry_seq(input logic [3:0] pkt_limit, input int exp_retries);
    logic got_retry;
    logic got_done;
    for (int t = 0; t <= exp_retries; t++) begin
      pulse_tx_done(1'b1, pkt_limit);
      pulse_bb_end();
      if (t % 2 == 1) begin
        pulse_sig(16'd14);
      end
      wait_try_end(got_retry, got_done, 100);
      check_val("start_retrans", got_retry, t < exp_retries);
      check_val("tx_try_complete", got_done, t == exp_retries);
    end
    check_val("tx_status.fail", tx_status.fail, 1);
    check_val("tx_status.num_retrans", tx_status.num_retrans, exp_retries);
    idle_cycles(10);
    check_val("retrans_in_progress", retrans_in_progress, 0);
    check_val("tx_control_idle", tx_control_idle, 1);
  endtask

  task automatic test_retry_limit();
    int e0;
    e0 = errors;
    run_retry_seq(4'd2, 2);
    // global limit overrides the per packet limit
    cfg.max_num_retrans = 4'd1;
    run_retry_seq(4'd2, 1);
    cfg.max_num_retrans = 4'd0;
    finish_test("test 5 retry limit", e0);
  endtask

  initial begin
    int n;
    seed_val                 = $urandom(29280);
    cfg.self_mac_addr        = random_mac();
    // even number of rate ones sets the signal parity bit
    cfg.ack_rate             = 4'b1111;
    cfg.duration_extra       = random_dur();
    cfg.ack_overhead         = 16'd44;
    cfg.send_ack_wait        = 15'd5;
    cfg.sig_valid_timeout    = 15'd20;
    cfg.ack_timeout          = 15'd30;
    cfg.max_num_retrans      = 4'd0;
    cfg.fcs_check_disable    = 1'b0;
    rx_frame                 = '0;
    fcs_done                 = 1'b0;
    rx_sig                   = '0;
    phy_tx_done              = 1'b0;
    tx_bb_end                = 1'b0;
    tx_pkt_need_ack          = 1'b0;
    tx_pkt_retrans_limit     = 4'd0;
    n = 0;
    while (rstn !== 1'b1 && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (rstn !== 1'b1) begin
      report_timeout("reset release");
    end
    @(negedge clk);
    test_reset_values();
    test_ack_last_frag();
    test_ack_more_frag();
    test_no_ack_needed();
    test_ack_received();
    test_retry_limit();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
logic/tx_ctrl_pkg.sv
logic/rx_frame_classifier.sv
logic/ack_frame_writer.sv
logic/ack_waiter.sv
logic/tx_control.sv
tb/tb_clock.sv
tb/tb_tx_control.sv
